// ==== src/uart_pkg.sv ====
package uart_pkg;

  ////////////////////////////////////////////////////////////
  // Bit timing
  ////////////////////////////////////////////////////////////

  // System clocks per serial bit
  localparam int unsigned CLKS_PER_BIT = 16;
  // Start edge to middle of start bit
  localparam int unsigned HALF_BIT     = CLKS_PER_BIT / 2;
  localparam int unsigned BIT_CNT_W    = $clog2(CLKS_PER_BIT);

  ////////////////////////////////////////////////////////////
  // Frame shape
  ////////////////////////////////////////////////////////////

  // 8N1: start bit, data bits, one stop bit
  localparam int unsigned DATA_BITS    = 8;
  localparam int unsigned FRAME_BITS   = DATA_BITS + 2;
  localparam int unsigned FRAME_CNT_W  = $clog2(FRAME_BITS);

endpackage

// ==== src/dbg_pkg.sv ====
package dbg_pkg;

  ////////////////////////////////////////////////////////////
  // Protocol bytes
  ////////////////////////////////////////////////////////////

  localparam logic [7:0] CMD_READ  = 8'h11;
  localparam logic [7:0] CMD_WRITE = 8'h12;
  localparam logic [7:0] CMD_EXEC  = 8'h13;
  localparam logic [7:0] RSP_ACK   = 8'h06;
  localparam logic [7:0] RSP_EOT   = 8'h04;

  ////////////////////////////////////////////////////////////
  // Field lengths
  ////////////////////////////////////////////////////////////

  // Address and length fields, both little-endian
  localparam int unsigned FIELD_BYTES = 8;
  localparam int unsigned HDR_CNT_W   = $clog2(2 * FIELD_BYTES);
  // Only the low length bytes are counted
  localparam int unsigned LEN_W       = 16;
  localparam int unsigned EXEC_ADDR_W = 64;

  // Memory geometry
  localparam int unsigned MEM_ADDR_W  = 10;
  localparam int unsigned MEM_BYTES   = 1 << MEM_ADDR_W;

  // FIFO depths
  localparam int unsigned RX_FIFO_DEPTH = 16;
  localparam int unsigned TX_FIFO_DEPTH = 8;
  localparam int unsigned CREDIT_W      = $clog2(TX_FIFO_DEPTH + 1);

endpackage

// ==== src/uart_rx.sv ====
`timescale 1ns/1ps

module uart_rx import uart_pkg::*; (
  input  logic                 clk,
  input  logic                 arst_n_i,
  input  logic                 rx_i,
  output logic                 valid_o,
  output logic [DATA_BITS-1:0] data_o
);

  typedef enum logic [1:0] {
    RX_IDLE,
    RX_START,
    RX_DATA,
    RX_STOP
  } rx_state_e;

  rx_state_e              state_q;
  logic                   rx_meta_q, rx_sync_q, rx_prev_q;
  logic [BIT_CNT_W-1:0]   clk_cnt_q;
  logic [FRAME_CNT_W-1:0] bit_cnt_q;
  logic [DATA_BITS-1:0]   shift_q;
  logic                   valid_q;
  logic                   bit_end;

  assign bit_end = clk_cnt_q == BIT_CNT_W'(CLKS_PER_BIT - 1);
  assign valid_o = valid_q;
  assign data_o  = shift_q;

  // Two-flop synchronizer plus one flop for edge detection
  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      rx_meta_q <= 1'b1;
      rx_sync_q <= 1'b1;
      rx_prev_q <= 1'b1;
    end else begin
      rx_meta_q <= rx_i;
      rx_sync_q <= rx_meta_q;
      rx_prev_q <= rx_sync_q;
    end
  end

  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q   <= RX_IDLE;
      clk_cnt_q <= '0;
      bit_cnt_q <= '0;
      valid_q   <= 1'b0;
    end else begin
      valid_q   <= 1'b0;
      clk_cnt_q <= clk_cnt_q + 1'b1;
      case (state_q)
        RX_IDLE: begin
          clk_cnt_q <= '0;
          if (rx_prev_q && !rx_sync_q) state_q <= RX_START;
        end
        RX_START: begin
          // Glitch filter at middle of start bit
          if (clk_cnt_q == BIT_CNT_W'(HALF_BIT - 1)) begin
            clk_cnt_q <= '0;
            bit_cnt_q <= '0;
            state_q   <= rx_sync_q ? RX_IDLE : RX_DATA;
          end
        end
        RX_DATA: begin
          if (bit_end) begin
            bit_cnt_q <= bit_cnt_q + 1'b1;
            if (bit_cnt_q == FRAME_CNT_W'(DATA_BITS - 1)) state_q <= RX_STOP;
          end
        end
        default: begin
          // Frames with a low stop bit are dropped
          if (bit_end) begin
            valid_q <= rx_sync_q;
            state_q <= RX_IDLE;
          end
        end
      endcase
    end
  end

  // LSB arrives first
  always_ff @(posedge clk) begin
    if (state_q == RX_DATA && bit_end) shift_q <= {rx_sync_q, shift_q[DATA_BITS-1:1]};
  end

endmodule

// ==== src/uart_tx.sv ====
`timescale 1ns/1ps

module uart_tx import uart_pkg::*; (
  input  logic                 clk,
  input  logic                 arst_n_i,
  input  logic                 empty_i,
  input  logic [DATA_BITS-1:0] data_i,
  output logic                 pop_o,
  output logic                 tx_o
);

  logic                   busy_q;
  logic [FRAME_BITS-1:0]  frame_q;
  logic [BIT_CNT_W-1:0]   clk_cnt_q;
  logic [FRAME_CNT_W-1:0] bit_cnt_q;

  assign pop_o = !busy_q && !empty_i;
  // Shift register refills with ones, so the line idles high
  assign tx_o  = frame_q[0];

  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      busy_q    <= 1'b0;
      frame_q   <= '1;
      clk_cnt_q <= '0;
      bit_cnt_q <= '0;
    end else if (pop_o) begin
      busy_q    <= 1'b1;
      frame_q   <= {1'b1, data_i, 1'b0};
      clk_cnt_q <= '0;
      bit_cnt_q <= '0;
    end else if (busy_q) begin
      if (clk_cnt_q == BIT_CNT_W'(CLKS_PER_BIT - 1)) begin
        clk_cnt_q <= '0;
        frame_q   <= {1'b1, frame_q[FRAME_BITS-1:1]};
        // Stop bit done
        if (bit_cnt_q == FRAME_CNT_W'(FRAME_BITS - 1)) begin
          busy_q <= 1'b0;
        end else begin
          bit_cnt_q <= bit_cnt_q + 1'b1;
        end
      end else begin
        clk_cnt_q <= clk_cnt_q + 1'b1;
      end
    end
  end

endmodule

// ==== src/byte_fifo.sv ====
`timescale 1ns/1ps

module byte_fifo import dbg_pkg::*; #(
  parameter int unsigned DEPTH = TX_FIFO_DEPTH
) (
  input  logic       clk,
  input  logic       arst_n_i,
  input  logic       push_i,
  input  logic [7:0] data_i,
  input  logic       pop_i,
  output logic [7:0] data_o,
  output logic       empty_o,
  output logic       credit_o
);

  localparam int unsigned PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;

  logic [7:0]       mem_q [DEPTH];
  logic [PTR_W-1:0] wr_ptr_q, rd_ptr_q;
  logic [PTR_W:0]   count_q;
  logic             full, do_push, do_pop;

  assign full     = count_q == (PTR_W + 1)'(DEPTH);
  assign empty_o  = count_q == '0;
  // A push into a full FIFO is lost
  assign do_push  = push_i && !full;
  assign do_pop   = pop_i && !empty_o;
  assign credit_o = do_pop;
  assign data_o   = mem_q[rd_ptr_q];

  always_ff @(posedge clk) begin
    if (do_push) mem_q[wr_ptr_q] <= data_i;
  end

  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (do_push) wr_ptr_q <= (wr_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
      if (do_pop) rd_ptr_q <= (rd_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
      if (do_push && !do_pop) count_q <= count_q + 1'b1;
      else if (!do_push && do_pop) count_q <= count_q - 1'b1;
    end
  end

endmodule

// ==== src/dbg_mem.sv ====
`timescale 1ns/1ps

module dbg_mem import dbg_pkg::*; (
  input  logic                  clk,
  input  logic                  en_i,
  input  logic                  we_i,
  input  logic [MEM_ADDR_W-1:0] addr_i,
  input  logic [7:0]            wdata_i,
  output logic [7:0]            rdata_o
);

  logic [7:0] mem_q [MEM_BYTES];

  // Single port, read data one cycle after request
  always_ff @(posedge clk) begin
    if (en_i) begin
      if (we_i) begin
        mem_q[addr_i] <= wdata_i;
      end else begin
        rdata_o <= mem_q[addr_i];
      end
    end
  end

endmodule

// ==== src/dbg_server.sv ====
`timescale 1ns/1ps

module dbg_server import dbg_pkg::*; (
  input  logic                   clk,
  input  logic                   arst_n_i,
  input  logic                   rx_empty_i,
  input  logic [7:0]             rx_data_i,
  output logic                   rx_pop_o,
  output logic                   tx_push_o,
  output logic [7:0]             tx_data_o,
  input  logic                   tx_credit_i,
  output logic                   mem_en_o,
  output logic                   mem_we_o,
  output logic [MEM_ADDR_W-1:0]  mem_addr_o,
  output logic [7:0]             mem_wdata_o,
  input  logic [7:0]             mem_rdata_i,
  output logic                   exec_valid_o,
  output logic [EXEC_ADDR_W-1:0] exec_addr_o
);

  typedef enum logic [2:0] {
    S_IDLE,
    S_HDR,
    S_ACK,
    S_RD_REQ,
    S_RD_DATA,
    S_WR_DATA,
    S_EOT
  } state_e;

  state_e                 state_q;
  logic [7:0]             op_q;
  logic [HDR_CNT_W-1:0]   hdr_cnt_q;
  logic [CREDIT_W-1:0]    credit_q;
  logic [EXEC_ADDR_W-1:0] addr_q;
  logic [LEN_W-1:0]       len_q;
  logic                   has_credit, hdr_last, len_field, rd_fire, wr_fire, last_byte;

  ////////////////////////////////////////////////////////////
  // Handshakes
  ////////////////////////////////////////////////////////////

  assign has_credit = credit_q != '0;
  assign rx_pop_o   = !rx_empty_i && (state_q inside {S_IDLE, S_HDR, S_WR_DATA});
  assign tx_push_o  = has_credit && (state_q inside {S_ACK, S_RD_DATA, S_EOT});
  assign rd_fire    = tx_push_o && state_q == S_RD_DATA;
  assign wr_fire    = rx_pop_o && state_q == S_WR_DATA;
  assign last_byte  = len_q == LEN_W'(1);

  always_comb begin
    case (state_q)
      S_RD_DATA: tx_data_o = mem_rdata_i;
      S_EOT:     tx_data_o = RSP_EOT;
      default:   tx_data_o = RSP_ACK;
    endcase
  end

  // Memory port, address wraps by truncation
  assign mem_en_o    = wr_fire || state_q == S_RD_REQ;
  assign mem_we_o    = wr_fire;
  assign mem_addr_o  = addr_q[MEM_ADDR_W-1:0];
  assign mem_wdata_o = rx_data_i;

  // Exec fires together with its ACK
  assign exec_valid_o = tx_push_o && state_q == S_ACK && op_q == CMD_EXEC;
  assign exec_addr_o  = addr_q;

  // Exec carries only the address field
  assign hdr_last  = (op_q == CMD_EXEC) ? hdr_cnt_q == HDR_CNT_W'(FIELD_BYTES - 1)
                                        : hdr_cnt_q == HDR_CNT_W'(2 * FIELD_BYTES - 1);
  assign len_field = hdr_cnt_q >= HDR_CNT_W'(FIELD_BYTES) &&
                     hdr_cnt_q < HDR_CNT_W'(FIELD_BYTES + LEN_W / 8);

  ////////////////////////////////////////////////////////////
  // Protocol FSM
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q   <= S_IDLE;
      op_q      <= '0;
      hdr_cnt_q <= '0;
    end else begin
      case (state_q)
        S_IDLE: begin
          hdr_cnt_q <= '0;
          if (rx_pop_o) begin
            op_q <= rx_data_i;
            if (rx_data_i == RSP_ACK) state_q <= S_ACK;
            else if (rx_data_i inside {CMD_READ, CMD_WRITE, CMD_EXEC}) state_q <= S_HDR;
          end
        end
        S_HDR: begin
          if (rx_pop_o) begin
            hdr_cnt_q <= hdr_cnt_q + 1'b1;
            if (hdr_last) state_q <= S_ACK;
          end
        end
        S_ACK: begin
          if (tx_push_o) begin
            if (op_q == CMD_READ) state_q <= (len_q == '0) ? S_EOT : S_RD_REQ;
            else if (op_q == CMD_WRITE) state_q <= (len_q == '0) ? S_EOT : S_WR_DATA;
            else state_q <= S_IDLE;
          end
        end
        S_RD_REQ: state_q <= S_RD_DATA;
        S_RD_DATA: begin
          // Read data stays on the memory port while out of credits
          if (rd_fire) state_q <= last_byte ? S_EOT : S_RD_REQ;
        end
        S_WR_DATA: begin
          if (wr_fire && last_byte) state_q <= S_EOT;
        end
        default: begin
          if (tx_push_o) state_q <= S_IDLE;
        end
      endcase
    end
  end

  // Header fields shift in LSB byte first
  always_ff @(posedge clk) begin
    if (state_q == S_HDR && rx_pop_o) begin
      if (hdr_cnt_q < HDR_CNT_W'(FIELD_BYTES)) begin
        addr_q <= {rx_data_i, addr_q[EXEC_ADDR_W-1:8]};
      end else if (len_field) begin
        len_q <= {rx_data_i, len_q[LEN_W-1:8]};
      end
    end else if (rd_fire || wr_fire) begin
      addr_q <= addr_q + 1'b1;
      len_q  <= len_q - 1'b1;
    end
  end

  // TX credits, one spent per push and one back per FIFO pop
  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      credit_q <= CREDIT_W'(TX_FIFO_DEPTH);
    end else if (tx_push_o && !tx_credit_i) begin
      credit_q <= credit_q - 1'b1;
    end else if (!tx_push_o && tx_credit_i) begin
      credit_q <= credit_q + 1'b1;
    end
  end

endmodule

// ==== src/uart_dbg_top.sv ====
`timescale 1ns/1ps

module uart_dbg_top import uart_pkg::*, dbg_pkg::*; (
  input  logic                   clk,
  input  logic                   arst_n_i,
  input  logic                   uart_rx_i,
  output logic                   uart_tx_o,
  output logic                   exec_valid_o,
  output logic [EXEC_ADDR_W-1:0] exec_addr_o
);

  logic                  rx_valid, rx_empty, rx_pop;
  logic [DATA_BITS-1:0]  rx_data, rx_fifo_data;
  logic                  tx_push, tx_empty, tx_pop, tx_credit;
  logic [DATA_BITS-1:0]  tx_data, tx_fifo_data;
  logic                  mem_en, mem_we;
  logic [MEM_ADDR_W-1:0] mem_addr;
  logic [7:0]            mem_wdata, mem_rdata;

  ////////////////////////////////////////////////////////////
  // Receive path
  ////////////////////////////////////////////////////////////

  uart_rx i_uart_rx (
    .clk      ( clk       ),
    .arst_n_i ( arst_n_i  ),
    .rx_i     ( uart_rx_i ),
    .valid_o  ( rx_valid  ),
    .data_o   ( rx_data   )
  );

  // Credit output unused, the line cannot be stalled
  byte_fifo #(
    .DEPTH ( RX_FIFO_DEPTH )
  ) i_rx_fifo (
    .clk      ( clk          ),
    .arst_n_i ( arst_n_i     ),
    .push_i   ( rx_valid     ),
    .data_i   ( rx_data      ),
    .pop_i    ( rx_pop       ),
    .data_o   ( rx_fifo_data ),
    .empty_o  ( rx_empty     ),
    .credit_o (              )
  );

  ////////////////////////////////////////////////////////////
  // Server and memory
  ////////////////////////////////////////////////////////////

  dbg_server i_dbg_server (
    .clk          ( clk          ),
    .arst_n_i     ( arst_n_i     ),
    .rx_empty_i   ( rx_empty     ),
    .rx_data_i    ( rx_fifo_data ),
    .rx_pop_o     ( rx_pop       ),
    .tx_push_o    ( tx_push      ),
    .tx_data_o    ( tx_data      ),
    .tx_credit_i  ( tx_credit    ),
    .mem_en_o     ( mem_en       ),
    .mem_we_o     ( mem_we       ),
    .mem_addr_o   ( mem_addr     ),
    .mem_wdata_o  ( mem_wdata    ),
    .mem_rdata_i  ( mem_rdata    ),
    .exec_valid_o ( exec_valid_o ),
    .exec_addr_o  ( exec_addr_o  )
  );

  dbg_mem i_dbg_mem (
    .clk     ( clk       ),
    .en_i    ( mem_en    ),
    .we_i    ( mem_we    ),
    .addr_i  ( mem_addr  ),
    .wdata_i ( mem_wdata ),
    .rdata_o ( mem_rdata )
  );

  ////////////////////////////////////////////////////////////
  // Transmit path
  ////////////////////////////////////////////////////////////

  byte_fifo #(
    .DEPTH ( TX_FIFO_DEPTH )
  ) i_tx_fifo (
    .clk      ( clk          ),
    .arst_n_i ( arst_n_i     ),
    .push_i   ( tx_push      ),
    .data_i   ( tx_data      ),
    .pop_i    ( tx_pop       ),
    .data_o   ( tx_fifo_data ),
    .empty_o  ( tx_empty     ),
    .credit_o ( tx_credit    )
  );

  uart_tx i_uart_tx (
    .clk      ( clk          ),
    .arst_n_i ( arst_n_i     ),
    .empty_i  ( tx_empty     ),
    .data_i   ( tx_fifo_data ),
    .pop_o    ( tx_pop       ),
    .tx_o     ( uart_tx_o    )
  );

endmodule

// ==== tests/uart_dbg_asserts.sv ====
`timescale 1ns/1ps

module uart_dbg_asserts import dbg_pkg::*; (
  input logic                clk,
  input logic                arst_n_i,
  input logic [CREDIT_W-1:0] credit_i,
  input logic                tx_push_i,
  input logic                tx_credit_i,
  input logic                exec_valid_i
);

  int fail_cnt;
  // Bytes pushed into the TX FIFO and not yet popped by the transmitter
  int in_fifo_q;

  initial fail_cnt = 0;

  always @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      in_fifo_q <= 0;
    end else begin
      in_fifo_q <= in_fifo_q + int'(tx_push_i) - int'(tx_credit_i);
    end
  end

  // Credits never exceed the TX FIFO slots
  credit_max: assert property (@(posedge clk) disable iff (!arst_n_i)
    credit_i <= CREDIT_W'(TX_FIFO_DEPTH))
    else begin
      $error("TX credit count %0d above FIFO depth", credit_i);
      fail_cnt++;
    end

  // A full FIFO drops the byte, even with a pop in the same cycle
  push_with_credit: assert property (@(posedge clk) disable iff (!arst_n_i)
    tx_push_i |-> in_fifo_q < int'(TX_FIFO_DEPTH))
    else begin
      $error("TX push issued with every FIFO slot taken");
      fail_cnt++;
    end

  // Single-cycle exec strobe
  exec_pulse: assert property (@(posedge clk) disable iff (!arst_n_i)
    exec_valid_i |=> !exec_valid_i)
    else begin
      $error("exec_valid_o held longer than one cycle");
      fail_cnt++;
    end

endmodule

bind dbg_server uart_dbg_asserts i_uart_dbg_asserts (
  .clk          ( clk          ),
  .arst_n_i     ( arst_n_i     ),
  .credit_i     ( credit_q     ),
  .tx_push_i    ( tx_push_o    ),
  .tx_credit_i  ( tx_credit_i  ),
  .exec_valid_i ( exec_valid_o )
);

// ==== tests/tb_uart_dbg.sv ====
`timescale 1ns/1ps

module tb_uart_dbg import uart_pkg::*, dbg_pkg::*; ();

  localparam int NUM_TESTS     = 9;
  localparam int CLK_PERIOD_NS = 8;
  localparam int FRAME_CYCLES  = FRAME_BITS * CLKS_PER_BIT;
  // Quiet time after the last expected byte, catches extra output
  localparam int SETTLE_CYCLES = 2 * FRAME_CYCLES;

  typedef enum {OP_CHALLENGE, OP_WRITE, OP_READ, OP_EXEC, OP_JUNK} op_e;

  logic                   clk;
  logic                   arst_n_i;
  logic                   uart_rx_i;
  logic                   uart_tx_o;
  logic                   exec_valid_o;
  logic [EXEC_ADDR_W-1:0] exec_addr_o;

  // Stimulus table, junk entries carry their byte in the address column
  string                  t_name [NUM_TESTS];
  op_e                    t_op   [NUM_TESTS];
  logic [63:0]            t_addr [NUM_TESTS];
  int                     t_len  [NUM_TESTS];
  logic [EXEC_ADDR_W-1:0] t_exec [NUM_TESTS];

  logic [7:0]             ref_mem [MEM_BYTES];
  logic [7:0]             rsp_q [$];
  integer                 seed;
  int                     err_cnt;
  int                     chk_cnt;
  int                     exec_count;
  logic [EXEC_ADDR_W-1:0] exec_addr_seen;
  longint                 limit_ns;

  uart_dbg_top i_uart_dbg_top (
    .clk          ( clk          ),
    .arst_n_i     ( arst_n_i     ),
    .uart_rx_i    ( uart_rx_i    ),
    .uart_tx_o    ( uart_tx_o    ),
    .exec_valid_o ( exec_valid_o ),
    .exec_addr_o  ( exec_addr_o  )
  );

  always #(CLK_PERIOD_NS / 2) clk = ~clk;

  ////////////////////////////////////////////////////////////
  // Host model
  ////////////////////////////////////////////////////////////

  // 8N1 frame, LSB first, called 1 ns after a rising edge
  task automatic send_byte(input logic [7:0] b);
    logic [9:0] frame;
    frame = {1'b1, b, 1'b0};
    for (int i = 0; i < FRAME_BITS; i++) begin
      uart_rx_i = frame[i];
      repeat (CLKS_PER_BIT) @(posedge clk);
      #1;
    end
  endtask

  task automatic send_field(input logic [63:0] value);
    for (int i = 0; i < FIELD_BYTES; i++) send_byte(value[8*i +: 8]);
  endtask

  // Line decoder, samples on the falling clock edge near mid-bit
  initial begin
    logic [7:0] data;
    wait (arst_n_i === 1'b1);
    forever begin
      @(negedge uart_tx_o);
      repeat (HALF_BIT) @(negedge clk);
      for (int i = 0; i < DATA_BITS; i++) begin
        repeat (CLKS_PER_BIT) @(negedge clk);
        data[i] = uart_tx_o;
      end
      repeat (CLKS_PER_BIT) @(negedge clk);
      assert (uart_tx_o === 1'b1) else begin
        $display("Stop bit on uart_tx_o was low, frame is broken");
        err_cnt++;
      end
      rsp_q.push_back(data);
    end
  end

  always @(negedge clk) begin
    if (exec_valid_o === 1'b1) begin
      exec_count++;
      exec_addr_seen = exec_addr_o;
    end
  end

  ////////////////////////////////////////////////////////////
  // Table
  ////////////////////////////////////////////////////////////

  task automatic set_entry(input int idx, input string name, input op_e op,
                           input logic [63:0] addr, input int len,
                           input logic [EXEC_ADDR_W-1:0] exec_addr);
    t_name[idx] = name;
    t_op[idx]   = op;
    t_addr[idx] = addr;
    t_len[idx]  = len;
    t_exec[idx] = exec_addr;
  endtask

  task automatic fill_table();
    set_entry(0, "challenge",       OP_CHALLENGE, 64'h0,    0,  64'h0);
    set_entry(1, "write_20",        OP_WRITE,     64'h40,   20, 64'h0);
    // Longer than the TX FIFO, so credits run out mid-read
    set_entry(2, "read_20",         OP_READ,      64'h40,   20, 64'h0);
    set_entry(3, "exec",            OP_EXEC,      64'h8000_1234_dead_beef, 0,
              64'h8000_1234_dead_beef);
    set_entry(4, "write_wrap",      OP_WRITE,     64'h405,  12, 64'h0);
    set_entry(5, "read_wrap",       OP_READ,      64'h5,    12, 64'h0);
    set_entry(6, "junk",            OP_JUNK,      64'h55,   0,  64'h0);
    set_entry(7, "challenge_again", OP_CHALLENGE, 64'h0,    0,  64'h0);
    set_entry(8, "read_empty",      OP_READ,      64'h100,  0,  64'h0);
  endtask

  // Frames sent plus frames returned plus the quiet time, per entry
  function automatic longint count_frames();
    longint total;
    total = 0;
    for (int t = 0; t < NUM_TESTS; t++) begin
      case (t_op[t])
        OP_CHALLENGE: total += 2;
        OP_WRITE:     total += 1 + 2 * FIELD_BYTES + t_len[t] + 2;
        OP_READ:      total += 1 + 2 * FIELD_BYTES + t_len[t] + 2;
        OP_EXEC:      total += 1 + FIELD_BYTES + 1;
        default:      total += 1;
      endcase
      total += SETTLE_CYCLES / FRAME_CYCLES;
    end
    return total;
  endfunction

  ////////////////////////////////////////////////////////////
  // Test sequence
  ////////////////////////////////////////////////////////////

  task automatic run_test(input int t);
    logic [7:0] exp_q [$];
    logic [7:0] b;
    int         exec_before;
    int         n;
    @(posedge clk);
    #1;
    rsp_q.delete();
    exec_before = exec_count;
    case (t_op[t])
      OP_CHALLENGE: begin
        send_byte(RSP_ACK);
        exp_q.push_back(RSP_ACK);
      end
      OP_EXEC: begin
        send_byte(CMD_EXEC);
        send_field(t_addr[t]);
        exp_q.push_back(RSP_ACK);
      end
      OP_WRITE: begin
        send_byte(CMD_WRITE);
        send_field(t_addr[t]);
        send_field(64'(t_len[t]));
        exp_q.push_back(RSP_ACK);
        for (int k = 0; k < t_len[t]; k++) begin
          b = 8'($random(seed));
          ref_mem[(t_addr[t] + k) % MEM_BYTES] = b;
          send_byte(b);
        end
        exp_q.push_back(RSP_EOT);
      end
      OP_READ: begin
        send_byte(CMD_READ);
        send_field(t_addr[t]);
        send_field(64'(t_len[t]));
        exp_q.push_back(RSP_ACK);
        for (int k = 0; k < t_len[t]; k++) begin
          exp_q.push_back(ref_mem[(t_addr[t] + k) % MEM_BYTES]);
        end
        exp_q.push_back(RSP_EOT);
      end
      default: send_byte(t_addr[t][7:0]);
    endcase

    while (rsp_q.size() < exp_q.size()) @(posedge clk);
    repeat (SETTLE_CYCLES) @(posedge clk);

    chk_cnt++;
    assert (rsp_q.size() == exp_q.size()) else begin
      $display("ERR %s: response bytes expected %0d, actual %0d",
               t_name[t], exp_q.size(), rsp_q.size());
      err_cnt++;
    end
    n = (rsp_q.size() < exp_q.size()) ? rsp_q.size() : exp_q.size();
    for (int k = 0; k < n; k++) begin
      chk_cnt++;
      assert (rsp_q[k] === exp_q[k]) else begin
        $display("ERR %s: byte %0d expected %02h, actual %02h",
                 t_name[t], k, exp_q[k], rsp_q[k]);
        err_cnt++;
      end
    end

    chk_cnt++;
    assert (exec_count - exec_before == ((t_op[t] == OP_EXEC) ? 1 : 0)) else begin
      $display("ERR %s: exec pulses expected %0d, actual %0d", t_name[t],
               (t_op[t] == OP_EXEC) ? 1 : 0, exec_count - exec_before);
      err_cnt++;
    end
    if (t_op[t] == OP_EXEC) begin
      chk_cnt++;
      assert (exec_addr_seen === t_exec[t]) else begin
        $display("ERR %s: exec address expected %016h, actual %016h",
                 t_name[t], t_exec[t], exec_addr_seen);
        err_cnt++;
      end
    end
  endtask

  initial begin
    clk        = 1'b0;
    arst_n_i   = 1'b0;
    uart_rx_i  = 1'b1;
    seed       = 32'h874b_133f;
    err_cnt    = 0;
    chk_cnt    = 0;
    exec_count = 0;
    fill_table();
    limit_ns = 2 * count_frames() * FRAME_CYCLES * CLK_PERIOD_NS;

    fork
      begin
        #(limit_ns);
        $display("Watchdog expired after %0d ns, the DUT stopped responding", limit_ns);
        $display("Regression failed");
        $finish;
      end
    join_none

    repeat (8) @(posedge clk);
    #1;
    arst_n_i = 1'b1;

    for (int t = 0; t < NUM_TESTS; t++) run_test(t);

    $display("Summary: %0d checks, %0d errors, %0d assertion failures", chk_cnt, err_cnt,
             i_uart_dbg_top.i_dbg_server.i_uart_dbg_asserts.fail_cnt);
    if (err_cnt == 0 && i_uart_dbg_top.i_dbg_server.i_uart_dbg_asserts.fail_cnt == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule

// ==== src.f ====
src/uart_pkg.sv
src/dbg_pkg.sv
src/uart_rx.sv
src/uart_tx.sv
src/byte_fifo.sv
src/dbg_mem.sv
src/dbg_server.sv
src/uart_dbg_top.sv
tests/uart_dbg_asserts.sv
tests/tb_uart_dbg.sv
